/* include/trap_defs.svh */
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

// data and address widths.
`define XLEN              32
`define CSR_ADDR_W        12
`define CAUSE_CODE_W      5

// machine csr addresses.
`define CSR_MSTATUS_ADDR  12'h300
`define CSR_MIE_ADDR      12'h304
`define CSR_MTVEC_ADDR    12'h305
`define CSR_MSCRATCH_ADDR 12'h340
`define CSR_MEPC_ADDR     12'h341
`define CSR_MCAUSE_ADDR   12'h342
`define CSR_MTVAL_ADDR    12'h343
`define CSR_MIP_ADDR      12'h344

// mstatus field positions.
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7
`define MSTATUS_MPP_LSB   11

// mie/mip positions, equal to the interrupt cause codes.
`define IRQ_MSIP_BIT      3
`define IRQ_MTIP_BIT      7
`define IRQ_MEIP_BIT      11

// interrupt flag in mcause.
`define CAUSE_INT_BIT     31

// write masks for the warl fields.
`define MTVEC_WR_MASK     32'hffff_fffd
`define MEPC_WR_MASK      32'hffff_fffe

// reset values.
`define CSR_RST_VAL       32'h0000_0000
`define CAUSE_RST_VAL     5'd0

`endif

/* design/trap_pkg.sv */
`include "trap_defs.svh"

package trap_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // only machine and user level are implemented.
    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_M = 2'd3
    } prv_e;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_pend_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    typedef enum logic [1:0] {
        EVT_NONE = 2'd0,
        EVT_TRAP = 2'd1,
        EVT_IRQ  = 2'd2,
        EVT_MRET = 2'd3
    } evt_kind_e;

    typedef struct packed {
        evt_kind_e kind;
        xlen_t     cause;
        xlen_t     tval;
        xlen_t     epc;
    } trap_evt_t;

    typedef struct packed {
        prv_e                    prv;
        logic                    mie_en;
        logic                    mpie;
        logic                    mpp_m;
        irq_pend_t               irq_en;
        irq_pend_t               irq_pend;
        xlen_t                   mtvec;
        xlen_t                   mscratch;
        xlen_t                   mepc;
        xlen_t                   mtval;
        logic                    cause_int;
        logic [`CAUSE_CODE_W-1:0] cause_code;
    } mach_state_t;

endpackage

/* design/irq_sync.sv */
`timescale 1ns/1ps

module irq_sync (
    input  logic                clk,
    input  logic                srstn,
    input  trap_pkg::irq_pend_t irq_raw,
    output trap_pkg::irq_pend_t irq_pend
);

    import trap_pkg::*;

    irq_pend_t sync_q1;
    irq_pend_t sync_q2;

    // lines come from other clock domains.
    always_ff @(posedge clk or negedge srstn) begin
        if (~srstn) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end
        else begin
            sync_q1 <= irq_raw;
            sync_q2 <= sync_q1;
        end
    end

    // second stage holds the hardware pending bits of mip.
    assign irq_pend = sync_q2;

endmodule

/* design/trap_ctrl.sv */
`timescale 1ns/1ps
`include "trap_defs.svh"

module trap_ctrl (
    input  trap_pkg::mach_state_t state,
    input  logic                  trap_en,
    input  trap_pkg::xlen_t       trap_epc,
    input  trap_pkg::xlen_t       trap_cause,
    input  trap_pkg::xlen_t       trap_val,
    input  logic                  mret,
    input  logic                  int_mask,
    output trap_pkg::trap_evt_t   evt,
    output logic                  irq_trigger,
    output logic                  eret_en,
    output trap_pkg::xlen_t       cause,
    output trap_pkg::xlen_t       tval,
    output trap_pkg::xlen_t       trap_vec,
    output trap_pkg::xlen_t       ret_epc
);

    import trap_pkg::*;

    irq_pend_t              en_pend;
    logic                   irq_ok;
    logic [`CAUSE_CODE_W-1:0] irq_code;
    evt_kind_e              kind;
    xlen_t                  vec_base;
    xlen_t                  vec_offset;

    assign en_pend = state.irq_en & state.irq_pend;

    // in user mode interrupts are taken regardless of mie.
    assign irq_ok = (|en_pend) && (state.prv == PRV_U || state.mie_en) && !int_mask;

    assign irq_trigger = irq_ok && !trap_en;
    assign eret_en     = mret && !trap_en;

    // external first, then software, then timer.
    assign irq_code = en_pend.meip ? `CAUSE_CODE_W'(`IRQ_MEIP_BIT) :
                      en_pend.msip ? `CAUSE_CODE_W'(`IRQ_MSIP_BIT) :
                                     `CAUSE_CODE_W'(`IRQ_MTIP_BIT);

    always_comb begin
        if (trap_en) begin
            kind = EVT_TRAP;
        end
        else if (irq_trigger) begin
            kind = EVT_IRQ;
        end
        else if (eret_en) begin
            kind = EVT_MRET;
        end
        else begin
            kind = EVT_NONE;
        end
    end

    always_comb begin
        cause = '0;
        tval  = '0;
        case (kind)
            EVT_TRAP: begin
                cause = trap_cause;
                tval  = trap_val;
            end
            EVT_IRQ: begin
                cause = {1'b1, {(`XLEN-`CAUSE_CODE_W-1){1'b0}}, irq_code};
            end
            default: begin
                cause = '0;
            end
        endcase
    end

    assign evt = '{kind: kind, cause: cause, tval: tval, epc: trap_epc};

    // vectored mode only offsets interrupts.
    assign vec_base   = {state.mtvec[`XLEN-1:2], 2'b00};
    assign vec_offset = (kind == EVT_IRQ && state.mtvec[0]) ?
                        {{(`XLEN-`CAUSE_CODE_W-2){1'b0}}, irq_code, 2'b00} : '0;
    assign trap_vec   = vec_base + vec_offset;

    assign ret_epc = state.mepc;

endmodule

/* design/csr_regfile.sv */
`timescale 1ns/1ps
`include "trap_defs.svh"

module csr_regfile (
    input  logic                  clk,
    input  logic                  srstn,
    input  trap_pkg::irq_pend_t   irq_pend,
    input  trap_pkg::trap_evt_t   evt,
    input  trap_pkg::csr_wr_t     csr_wr,
    output trap_pkg::mach_state_t state
);

    import trap_pkg::*;

    prv_e                     prv_q;
    logic                     mie_en_q;
    logic                     mpie_q;
    logic                     mpp_m_q;
    irq_pend_t                irq_en_q;
    xlen_t                    mtvec_q;
    xlen_t                    mscratch_q;
    xlen_t                    mepc_q;
    xlen_t                    mtval_q;
    logic                     cause_int_q;
    logic [`CAUSE_CODE_W-1:0] cause_code_q;

    logic                     take_entry;
    logic                     take_mret;
    logic                     wr_ok;

    assign take_entry = (evt.kind == EVT_TRAP) || (evt.kind == EVT_IRQ);
    assign take_mret  = (evt.kind == EVT_MRET);

    // a write that collides with an event is dropped.
    assign wr_ok = csr_wr.en && (evt.kind == EVT_NONE);

    // privilege and mstatus.
    always_ff @(posedge clk or negedge srstn) begin
        if (~srstn) begin
            prv_q    <= PRV_M;
            mie_en_q <= 1'b0;
            mpie_q   <= 1'b0;
            mpp_m_q  <= 1'b0;
        end
        else if (take_entry) begin
            prv_q    <= PRV_M;
            mpie_q   <= mie_en_q;
            mie_en_q <= 1'b0;
            mpp_m_q  <= (prv_q == PRV_M);
        end
        else if (take_mret) begin
            prv_q    <= mpp_m_q ? PRV_M : PRV_U;
            mie_en_q <= mpie_q;
            mpie_q   <= 1'b1;
            mpp_m_q  <= 1'b0;
        end
        else if (wr_ok && csr_wr.addr == `CSR_MSTATUS_ADDR) begin
            mie_en_q <= csr_wr.data[`MSTATUS_MIE_BIT];
            mpie_q   <= csr_wr.data[`MSTATUS_MPIE_BIT];
            // mpp is warl, any nonzero value maps to M.
            mpp_m_q  <= |csr_wr.data[`MSTATUS_MPP_LSB+1:`MSTATUS_MPP_LSB];
        end
    end

    // trap handling registers.
    always_ff @(posedge clk or negedge srstn) begin
        if (~srstn) begin
            mepc_q       <= `CSR_RST_VAL;
            mtval_q      <= `CSR_RST_VAL;
            cause_int_q  <= 1'b0;
            cause_code_q <= `CAUSE_RST_VAL;
        end
        else if (take_entry) begin
            mepc_q       <= evt.epc;
            mtval_q      <= evt.tval;
            cause_int_q  <= evt.cause[`CAUSE_INT_BIT];
            cause_code_q <= evt.cause[`CAUSE_CODE_W-1:0];
        end
        else if (wr_ok) begin
            case (csr_wr.addr)
                `CSR_MEPC_ADDR:  mepc_q  <= csr_wr.data & `MEPC_WR_MASK;
                `CSR_MTVAL_ADDR: mtval_q <= csr_wr.data;
                `CSR_MCAUSE_ADDR: begin
                    cause_int_q  <= csr_wr.data[`CAUSE_INT_BIT];
                    cause_code_q <= csr_wr.data[`CAUSE_CODE_W-1:0];
                end
                default: begin
                    cause_int_q <= cause_int_q;
                end
            endcase
        end
    end

    // setup registers, changed only by software.
    always_ff @(posedge clk or negedge srstn) begin
        if (~srstn) begin
            irq_en_q   <= '0;
            mtvec_q    <= `CSR_RST_VAL;
            mscratch_q <= `CSR_RST_VAL;
        end
        else if (wr_ok) begin
            case (csr_wr.addr)
                `CSR_MIE_ADDR: begin
                    irq_en_q.meip <= csr_wr.data[`IRQ_MEIP_BIT];
                    irq_en_q.mtip <= csr_wr.data[`IRQ_MTIP_BIT];
                    irq_en_q.msip <= csr_wr.data[`IRQ_MSIP_BIT];
                end
                `CSR_MTVEC_ADDR:    mtvec_q    <= csr_wr.data & `MTVEC_WR_MASK;
                `CSR_MSCRATCH_ADDR: mscratch_q <= csr_wr.data;
                default: begin
                    mtvec_q <= mtvec_q;
                end
            endcase
        end
    end

    // mip is read only, it mirrors the synchronized lines.
    assign state = '{
        prv:        prv_q,
        mie_en:     mie_en_q,
        mpie:       mpie_q,
        mpp_m:      mpp_m_q,
        irq_en:     irq_en_q,
        irq_pend:   irq_pend,
        mtvec:      mtvec_q,
        mscratch:   mscratch_q,
        mepc:       mepc_q,
        mtval:      mtval_q,
        cause_int:  cause_int_q,
        cause_code: cause_code_q
    };

endmodule

/* design/csr_read_mux.sv */
`timescale 1ns/1ps
`include "trap_defs.svh"

module csr_read_mux (
    input  trap_pkg::mach_state_t state,
    input  trap_pkg::csr_addr_t   csr_raddr,
    output trap_pkg::xlen_t       csr_rdata
);

    import trap_pkg::*;

    xlen_t mstatus_img;
    xlen_t mie_img;
    xlen_t mip_img;
    xlen_t mcause_img;

    always_comb begin
        mstatus_img = '0;
        mstatus_img[`MSTATUS_MIE_BIT]  = state.mie_en;
        mstatus_img[`MSTATUS_MPIE_BIT] = state.mpie;
        mstatus_img[`MSTATUS_MPP_LSB+1:`MSTATUS_MPP_LSB] = {2{state.mpp_m}};

        mie_img = '0;
        mie_img[`IRQ_MEIP_BIT] = state.irq_en.meip;
        mie_img[`IRQ_MTIP_BIT] = state.irq_en.mtip;
        mie_img[`IRQ_MSIP_BIT] = state.irq_en.msip;

        mip_img = '0;
        mip_img[`IRQ_MEIP_BIT] = state.irq_pend.meip;
        mip_img[`IRQ_MTIP_BIT] = state.irq_pend.mtip;
        mip_img[`IRQ_MSIP_BIT] = state.irq_pend.msip;
    end

    assign mcause_img = {state.cause_int, {(`XLEN-`CAUSE_CODE_W-1){1'b0}}, state.cause_code};

    // unimplemented addresses read as zero.
    always_comb begin
        case (csr_raddr)
            `CSR_MSTATUS_ADDR:  csr_rdata = mstatus_img;
            `CSR_MIE_ADDR:      csr_rdata = mie_img;
            `CSR_MTVEC_ADDR:    csr_rdata = state.mtvec;
            `CSR_MSCRATCH_ADDR: csr_rdata = state.mscratch;
            `CSR_MEPC_ADDR:     csr_rdata = state.mepc;
            `CSR_MCAUSE_ADDR:   csr_rdata = mcause_img;
            `CSR_MTVAL_ADDR:    csr_rdata = state.mtval;
            `CSR_MIP_ADDR:      csr_rdata = mip_img;
            default:            csr_rdata = '0;
        endcase
    end

endmodule

/* design/trap_unit.sv */
`timescale 1ns/1ps

module trap_unit (
    input  logic                clk,
    input  logic                srstn,

    // interrupt lines and trap requests from the core.
    input  trap_pkg::irq_pend_t irq_raw,
    input  logic                int_mask,
    input  logic                trap_en,
    input  trap_pkg::xlen_t     trap_epc,
    input  trap_pkg::xlen_t     trap_cause,
    input  trap_pkg::xlen_t     trap_val,
    input  logic                mret,

    // csr port.
    input  trap_pkg::csr_wr_t   csr_wr,
    input  trap_pkg::csr_addr_t csr_raddr,
    output trap_pkg::xlen_t     csr_rdata,

    // pc control.
    output logic                irq_trigger,
    output logic                eret_en,
    output trap_pkg::xlen_t     cause,
    output trap_pkg::xlen_t     tval,
    output trap_pkg::xlen_t     trap_vec,
    output trap_pkg::xlen_t     ret_epc,
    output trap_pkg::prv_e      prv
);

    import trap_pkg::*;

    irq_pend_t   irq_pend;
    mach_state_t state;
    trap_evt_t   evt;

    irq_sync u_irq_sync (
        .clk      (clk),
        .srstn    (srstn),
        .irq_raw  (irq_raw),
        .irq_pend (irq_pend)
    );

    trap_ctrl u_trap_ctrl (
        .state       (state),
        .trap_en     (trap_en),
        .trap_epc    (trap_epc),
        .trap_cause  (trap_cause),
        .trap_val    (trap_val),
        .mret        (mret),
        .int_mask    (int_mask),
        .evt         (evt),
        .irq_trigger (irq_trigger),
        .eret_en     (eret_en),
        .cause       (cause),
        .tval        (tval),
        .trap_vec    (trap_vec),
        .ret_epc     (ret_epc)
    );

    csr_regfile u_csr_regfile (
        .clk      (clk),
        .srstn    (srstn),
        .irq_pend (irq_pend),
        .evt      (evt),
        .csr_wr   (csr_wr),
        .state    (state)
    );

    csr_read_mux u_csr_read_mux (
        .state     (state),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata)
    );

    assign prv = state.prv;

endmodule

/* verif/tb_trap_unit.sv */
`timescale 1ns/1ps
`include "trap_defs.svh"

module tb_trap_unit;

    import trap_pkg::*;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_TRAP,
        OP_MRET,
        OP_IRQ,
        OP_IDLE
    } op_e;

    typedef struct packed {
        op_e       op;
        csr_addr_t addr;
        xlen_t     data;
        xlen_t     epc;
        xlen_t     cause;
        xlen_t     val;
        irq_pend_t irq;
        logic      mask;
        xlen_t     expv;
    } step_t;

    logic      clk;
    logic      srstn;
    irq_pend_t irq_raw;
    logic      int_mask;
    logic      trap_en;
    xlen_t     trap_epc;
    xlen_t     trap_cause;
    xlen_t     trap_val;
    logic      mret;
    csr_wr_t   csr_wr;
    csr_addr_t csr_raddr;
    xlen_t     csr_rdata;
    logic      irq_trigger;
    logic      eret_en;
    xlen_t     cause;
    xlen_t     tval;
    xlen_t     trap_vec;
    xlen_t     ret_epc;
    prv_e      prv;

    step_t     steps[$];
    int        cycle_count;
    int        cycle_limit;

    // reference model state as architectural csr words.
    prv_e      m_prv;
    xlen_t     m_mstatus;
    xlen_t     m_mie;
    xlen_t     m_mtvec;
    xlen_t     m_mscratch;
    xlen_t     m_mepc;
    xlen_t     m_mcause;
    xlen_t     m_mtval;
    irq_pend_t m_sync1;
    irq_pend_t m_sync2;

    logic      exp_trap;
    logic      exp_trig;
    logic      exp_eret;
    xlen_t     exp_cause;
    xlen_t     exp_tval;
    xlen_t     exp_vec;

    trap_unit u_trap_unit (
        .clk         (clk),
        .srstn       (srstn),
        .irq_raw     (irq_raw),
        .int_mask    (int_mask),
        .trap_en     (trap_en),
        .trap_epc    (trap_epc),
        .trap_cause  (trap_cause),
        .trap_val    (trap_val),
        .mret        (mret),
        .csr_wr      (csr_wr),
        .csr_raddr   (csr_raddr),
        .csr_rdata   (csr_rdata),
        .irq_trigger (irq_trigger),
        .eret_en     (eret_en),
        .cause       (cause),
        .tval        (tval),
        .trap_vec    (trap_vec),
        .ret_epc     (ret_epc),
        .prv         (prv)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            abort_run("timeout: the test steps did not finish within the cycle limit");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_word(input string name, input xlen_t expv, input xlen_t actv);
        if (actv !== expv) begin
            abort_run($sformatf("[FAIL] %0t ns %s expected %h actual %h",
                                $time, name, expv, actv));
        end
    endtask

    task automatic check_prv(input string name, input prv_e expv, input prv_e actv);
        if (actv !== expv) begin
            abort_run($sformatf("[FAIL] %0t ns %s expected %0d actual %0d",
                                $time, name, expv, actv));
        end
    endtask

    task automatic check_bit(input string name, input logic expv, input logic actv);
        if (actv !== expv) begin
            abort_run($sformatf("[FAIL] %0t ns %s expected %b actual %b",
                                $time, name, expv, actv));
        end
    endtask

    function automatic xlen_t irq_word(input irq_pend_t bits);
        xlen_t w;
        w = '0;
        w[`IRQ_MEIP_BIT] = bits.meip;
        w[`IRQ_MTIP_BIT] = bits.mtip;
        w[`IRQ_MSIP_BIT] = bits.msip;
        return w;
    endfunction

    function automatic xlen_t csr_image(input csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS_ADDR:  csr_image = m_mstatus;
            `CSR_MIE_ADDR:      csr_image = m_mie;
            `CSR_MTVEC_ADDR:    csr_image = m_mtvec;
            `CSR_MSCRATCH_ADDR: csr_image = m_mscratch;
            `CSR_MEPC_ADDR:     csr_image = m_mepc;
            `CSR_MCAUSE_ADDR:   csr_image = m_mcause;
            `CSR_MTVAL_ADDR:    csr_image = m_mtval;
            `CSR_MIP_ADDR:      csr_image = irq_word(m_sync2);
            default:            csr_image = '0;
        endcase
    endfunction

    task automatic load_steps();
        int          fd;
        int          n;
        int          lineno;
        string       line;
        string       op_s;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_epc;
        logic [31:0] f_cause;
        logic [31:0] f_val;
        logic [31:0] f_irq;
        logic [31:0] f_mask;
        logic [31:0] f_exp;
        step_t       s;
        lineno = 0;
        fd = $fopen("verif/trap_unit_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the test data file verif/trap_unit_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            lineno = lineno + 1;
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", op_s, f_addr, f_data,
                        f_epc, f_cause, f_val, f_irq, f_mask, f_exp);
            // blank lines and lines starting with a hash carry no step.
            if (n > 0 && op_s.substr(0, 0) != "#") begin
                if (n != 9) begin
                    abort_run($sformatf("line %0d of the test data file is malformed", lineno));
                end
                case (op_s)
                    "write": s.op = OP_WRITE;
                    "read":  s.op = OP_READ;
                    "trap":  s.op = OP_TRAP;
                    "mret":  s.op = OP_MRET;
                    "irq":   s.op = OP_IRQ;
                    "idle":  s.op = OP_IDLE;
                    default: abort_run($sformatf("line %0d has an unknown operation", lineno));
                endcase
                s.addr  = f_addr[`CSR_ADDR_W-1:0];
                s.data  = f_data;
                s.epc   = f_epc;
                s.cause = f_cause;
                s.val   = f_val;
                s.irq   = irq_pend_t'(f_irq[2:0]);
                s.mask  = f_mask[0];
                s.expv  = f_exp;
                steps.push_back(s);
            end
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            abort_run("the test data file holds no test steps");
        end
    endtask

    task automatic apply_inputs(input step_t s);
        irq_raw     = s.irq;
        int_mask    = s.mask;
        trap_en     = (s.op == OP_TRAP);
        trap_epc    = s.epc;
        trap_cause  = s.cause;
        trap_val    = s.val;
        mret        = (s.op == OP_MRET);
        csr_wr.en   = (s.op == OP_WRITE);
        csr_wr.addr = s.addr;
        csr_wr.data = s.data;
        csr_raddr   = s.addr;
    endtask

    task automatic predict_outputs(input step_t s);
        xlen_t                    pend;
        logic                     eligible;
        logic [`CAUSE_CODE_W-1:0] code;
        pend = m_mie & irq_word(m_sync2);
        if (pend[`IRQ_MEIP_BIT]) begin
            code = `CAUSE_CODE_W'(`IRQ_MEIP_BIT);
        end
        else if (pend[`IRQ_MSIP_BIT]) begin
            code = `CAUSE_CODE_W'(`IRQ_MSIP_BIT);
        end
        else begin
            code = `CAUSE_CODE_W'(`IRQ_MTIP_BIT);
        end
        eligible = (pend != '0) && (m_prv == PRV_U || m_mstatus[`MSTATUS_MIE_BIT]) && !s.mask;
        exp_trap  = (s.op == OP_TRAP);
        exp_trig  = eligible && !exp_trap;
        exp_eret  = (s.op == OP_MRET) && !exp_trap;
        exp_cause = '0;
        exp_tval  = '0;
        exp_vec   = m_mtvec & 32'hffff_fffc;
        if (exp_trap) begin
            exp_cause = s.cause;
            exp_tval  = s.val;
        end
        else if (exp_trig) begin
            exp_cause = 32'h8000_0000 | xlen_t'(code);
            if (m_mtvec[0]) begin
                exp_vec = exp_vec + (xlen_t'(code) << 2);
            end
        end
    endtask

    task automatic compare_outputs(input step_t s);
        check_prv("prv", m_prv, prv);
        check_bit("irq_trigger", exp_trig, irq_trigger);
        check_bit("eret_en", exp_eret, eret_en);
        check_word("cause", exp_cause, cause);
        check_word("tval", exp_tval, tval);
        check_word("trap_vec", exp_vec, trap_vec);
        check_word("ret_epc", m_mepc, ret_epc);
        check_word("csr_rdata", csr_image(s.addr), csr_rdata);
        if (s.op == OP_READ) begin
            check_word("csr_rdata against file", s.expv, csr_rdata);
        end
        if (s.op == OP_IRQ) begin
            check_word("cause against file", s.expv, cause);
        end
    endtask

    // every implemented csr through the combinational read port.
    task automatic sweep_csr_reads(input step_t s);
        csr_addr_t addrs [8];
        addrs = '{`CSR_MSTATUS_ADDR, `CSR_MIE_ADDR, `CSR_MTVEC_ADDR, `CSR_MSCRATCH_ADDR,
                  `CSR_MEPC_ADDR, `CSR_MCAUSE_ADDR, `CSR_MTVAL_ADDR, `CSR_MIP_ADDR};
        foreach (addrs[i]) begin
            csr_raddr = addrs[i];
            #0.2;
            check_word($sformatf("csr_rdata at %h", addrs[i]), csr_image(addrs[i]),
                       csr_rdata);
        end
        csr_raddr = s.addr;
    endtask

    // next state at the coming rising edge.
    task automatic advance_model(input step_t s);
        xlen_t old_st;
        old_st = m_mstatus;
        if (exp_trap || exp_trig) begin
            m_mstatus = '0;
            m_mstatus[`MSTATUS_MPIE_BIT] = old_st[`MSTATUS_MIE_BIT];
            if (m_prv == PRV_M) begin
                m_mstatus[`MSTATUS_MPP_LSB+1:`MSTATUS_MPP_LSB] = 2'b11;
            end
            m_prv    = PRV_M;
            m_mepc   = s.epc;
            m_mcause = exp_cause & 32'h8000_001f;
            m_mtval  = exp_tval;
        end
        else if (exp_eret) begin
            m_prv = old_st[`MSTATUS_MPP_LSB] ? PRV_M : PRV_U;
            m_mstatus = '0;
            m_mstatus[`MSTATUS_MIE_BIT]  = old_st[`MSTATUS_MPIE_BIT];
            m_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
        end
        else if (s.op == OP_WRITE) begin
            case (s.addr)
                `CSR_MSTATUS_ADDR: begin
                    m_mstatus = s.data & 32'h0000_0088;
                    if (s.data[`MSTATUS_MPP_LSB+1:`MSTATUS_MPP_LSB] != 2'b00) begin
                        m_mstatus[`MSTATUS_MPP_LSB+1:`MSTATUS_MPP_LSB] = 2'b11;
                    end
                end
                `CSR_MIE_ADDR:      m_mie      = s.data & 32'h0000_0888;
                `CSR_MTVEC_ADDR:    m_mtvec    = s.data & 32'hffff_fffd;
                `CSR_MSCRATCH_ADDR: m_mscratch = s.data;
                `CSR_MEPC_ADDR:     m_mepc     = s.data & 32'hffff_fffe;
                `CSR_MCAUSE_ADDR:   m_mcause   = s.data & 32'h8000_001f;
                `CSR_MTVAL_ADDR:    m_mtval    = s.data;
                default: ;
            endcase
        end
        m_sync2 = m_sync1;
        m_sync1 = s.irq;
    endtask

    task automatic run_step(input step_t s);
        @(negedge clk);
        apply_inputs(s);
        #2;
        predict_outputs(s);
        compare_outputs(s);
        sweep_csr_reads(s);
        advance_model(s);
    endtask

    initial begin
        clk         = 1'b0;
        srstn       = 1'b0;
        irq_raw     = '0;
        int_mask    = 1'b0;
        trap_en     = 1'b0;
        trap_epc    = '0;
        trap_cause  = '0;
        trap_val    = '0;
        mret        = 1'b0;
        csr_wr      = '0;
        csr_raddr   = '0;
        cycle_count = 0;
        cycle_limit = 100;
        m_prv       = PRV_M;
        m_mstatus   = '0;
        m_mie       = '0;
        m_mtvec     = '0;
        m_mscratch  = '0;
        m_mepc      = '0;
        m_mcause    = '0;
        m_mtval     = '0;
        m_sync1     = '0;
        m_sync2     = '0;
        load_steps();
        cycle_limit = 8 * steps.size() + 100;
        repeat (10) @(posedge clk);
        @(negedge clk);
        srstn = 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

/* verif/trap_unit_tests.txt */
# op    addr data     epc      cause    val      irq mask expected   (numbers in hex)
# irq is meip,mtip,msip from msb; expected is read data for read, cause for irq
read    300  00000000 00000000 00000000 00000000 0   0    00000000
read    305  00000000 00000000 00000000 00000000 0   0    00000000
read    342  00000000 00000000 00000000 00000000 0   0    00000000
read    344  00000000 00000000 00000000 00000000 0   0    00000000
write   305  ffffffff 00000000 00000000 00000000 0   0    00000000
read    305  00000000 00000000 00000000 00000000 0   0    fffffffd
write   341  12345677 00000000 00000000 00000000 0   0    00000000
read    341  00000000 00000000 00000000 00000000 0   0    12345676
write   342  ffffffff 00000000 00000000 00000000 0   0    00000000
read    342  00000000 00000000 00000000 00000000 0   0    8000001f
write   300  ffffffff 00000000 00000000 00000000 0   0    00000000
read    300  00000000 00000000 00000000 00000000 0   0    00001888
write   340  a5a5a5a5 00000000 00000000 00000000 0   0    00000000
read    340  00000000 00000000 00000000 00000000 0   0    a5a5a5a5
write   344  ffffffff 00000000 00000000 00000000 0   0    00000000
read    344  00000000 00000000 00000000 00000000 0   0    00000000
write   305  00000100 00000000 00000000 00000000 0   0    00000000
write   300  00000008 00000000 00000000 00000000 0   0    00000000
trap    343  00000000 00000200 00000002 deadbeef 0   0    00000000
read    342  00000000 00000000 00000000 00000000 0   0    00000002
read    300  00000000 00000000 00000000 00000000 0   0    00001880
write   300  00000080 00000000 00000000 00000000 0   0    00000000
mret    341  00000000 00000000 00000000 00000000 0   0    00000000
read    300  00000000 00000000 00000000 00000000 0   0    00000088
write   304  00000888 00000000 00000000 00000000 0   0    00000000
write   305  00000101 00000000 00000000 00000000 0   0    00000000
idle    344  00000000 00000000 00000000 00000000 7   1    00000000
idle    344  00000000 00000000 00000000 00000000 7   1    00000000
irq     344  00000000 00000000 00000000 00000000 7   1    00000000
trap    341  00000000 00000300 00000005 00000000 7   0    00000000
irq     300  00000000 00000000 00000000 00000000 7   0    00000000
write   300  00000008 00000000 00000000 00000000 7   0    00000000
irq     341  00000000 00000400 00000000 00000000 7   0    8000000b
write   300  00000008 00000000 00000000 00000000 3   0    00000000
idle    344  00000000 00000000 00000000 00000000 3   1    00000000
irq     342  00000000 00000500 00000000 00000000 3   0    80000003
write   300  00000008 00000000 00000000 00000000 2   0    00000000
idle    344  00000000 00000000 00000000 00000000 2   1    00000000
irq     342  00000000 00000600 00000000 00000000 2   0    80000007
read    344  00000000 00000000 00000000 00000000 2   0    00000080

/* filelist.f */
+incdir+include
design/trap_pkg.sv
design/irq_sync.sv
design/trap_ctrl.sv
design/csr_regfile.sv
design/csr_read_mux.sv
design/trap_unit.sv
verif/tb_trap_unit.sv

/* Makefile */
sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_trap_unit -f filelist.f
	./obj_dir/Vtb_trap_unit

clean:
	rm -rf obj_dir

.PHONY: sim clean
